// ==== Makefile ====
# Verilator simulation of the board control block

VERILATOR ?= verilator
TOP       ?= tb_board_ctl
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

# build, run, and fail unless the pass line appears
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/board_ctl_pkg.sv ====
`default_nettype none

package board_ctl_pkg;

	// ------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------
	localparam int NUM_PORTS   = 8;	// sfp cages on the card
	localparam int ADDR_W      = 10;	// local bus address
	localparam int DATA_W      = 8;	// local bus data
	localparam int BLINK_DIV_W = 4;	// short divider for sim, 22 on the board

	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [NUM_PORTS-1:0] port_vec_t;	// one bit per cage

	// identity bytes, read only
	localparam data_t ID_DATA_WIDTH    = 8'h00;
	localparam data_t ID_VERSION       = 8'h01;
	localparam data_t ID_BUILD_MONTH   = 8'ha8;	// year nibble + month nibble
	localparam data_t ID_BUILD_DATE    = 8'h03;
	localparam data_t ID_PCB_VERSION   = 8'h01;
	localparam data_t ID_BOARD_VERSION = 8'h01;
	localparam data_t ID_BOARD_CONFIG  = 8'hff;

	// ------------------------------------------------------------
	// register map
	// ------------------------------------------------------------
	localparam logic [ADDR_W-1:0] A_TEST          = 10'h000;
	localparam logic [ADDR_W-1:0] A_DATA_WIDTH    = 10'h001;
	localparam logic [ADDR_W-1:0] A_VERSION       = 10'h002;
	localparam logic [ADDR_W-1:0] A_BUILD_MONTH   = 10'h003;
	localparam logic [ADDR_W-1:0] A_BUILD_DATE    = 10'h004;
	localparam logic [ADDR_W-1:0] A_PCB_VERSION   = 10'h005;
	localparam logic [ADDR_W-1:0] A_BOARD_VERSION = 10'h006;
	localparam logic [ADDR_W-1:0] A_BOARD_CONFIG  = 10'h007;
	localparam logic [ADDR_W-1:0] A_INT_SOURCE    = 10'h027;	// read to clear
	localparam logic [ADDR_W-1:0] A_INT_MASK      = 10'h028;
	localparam logic [ADDR_W-1:0] A_TDO           = 10'h038;
	localparam logic [ADDR_W-1:0] A_TDI           = 10'h039;	// write only
	localparam logic [ADDR_W-1:0] A_TMS           = 10'h03b;	// write only
	localparam logic [ADDR_W-1:0] A_TCK           = 10'h03c;	// write only
	localparam logic [ADDR_W-1:0] A_TXDIS         = 10'h040;
	localparam logic [ADDR_W-1:0] A_LED_LINK      = 10'h041;
	localparam logic [ADDR_W-1:0] A_LED_ACT       = 10'h042;
	localparam logic [ADDR_W-1:0] A_JTAG_SEL      = 10'h043;
	localparam logic [ADDR_W-1:0] A_SFP_PRESENT   = 10'h050;	// debounced abs
	localparam logic [ADDR_W-1:0] A_SFP_LOS       = 10'h051;	// debounced los
	localparam logic [ADDR_W-1:0] A_ABS_EVENT     = 10'h052;	// read to clear
	localparam logic [ADDR_W-1:0] A_LOS_EVENT     = 10'h053;	// read to clear

	// reset values
	localparam data_t RST_INT_MASK = 8'hff;	// all sources enabled
	localparam data_t RST_LED_LINK = 8'hff;	// leds off
	localparam data_t RST_LED_ACT  = 8'hff;
	localparam data_t RST_TXDIS    = 8'h00;	// lasers on
	localparam data_t RST_JTAG_SEL = 8'h00;
	localparam data_t RST_TDI      = 8'hff;
	localparam data_t RST_TMS      = 8'hff;
	localparam data_t RST_TCK      = 8'h00;
	localparam data_t RST_TEST     = 8'h00;

	// ------------------------------------------------------------
	// bundles
	// ------------------------------------------------------------
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		data_t             wdata;
		logic              cs_n;
		logic              wr_n;
		logic              rd_n;
	} lbus_req_t;	// 21 bits

	typedef struct packed {
		data_t int_mask;
		data_t led_link;
		data_t led_act;
		data_t jtag_sel;
	} ctl_regs_t;

	// one-cycle pulses after a read of a clear-on-read register
	typedef struct packed {
		logic int_src;
		logic abs_evt;
		logic los_evt;
	} rd_clr_t;

	typedef struct packed {
		port_vec_t deb;		// debounced pin state
		port_vec_t evt_n;	// change events, active low
		logic      sum_n;	// low while any event pending
	} sfp_status_t;	// 17 bits

endpackage

`default_nettype wire

// ==== rtl/board_ctl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module board_ctl_top (
	input  wire                       clk,
	input  wire                       rst_n,
	input  board_ctl_pkg::lbus_req_t  lbus,
	output board_ctl_pkg::data_t      lbus_rdata,
	output logic                      rdata_oe,
	output logic                      rdy_n,
	output logic                      int_n,
	input  board_ctl_pkg::port_vec_t  sfp_abs_pin,
	input  board_ctl_pkg::port_vec_t  sfp_los_pin,
	output board_ctl_pkg::port_vec_t  txdis,
	output board_ctl_pkg::port_vec_t  led,
	input  wire                       vmon_alarm_n,
	input  wire                       temp_alarm_n,
	output logic                      tck,
	output logic                      tdi,
	output logic                      tms,
	output logic                      jtag_con,
	output logic                      jtag_sys,
	input  wire                       tdo
);

	board_ctl_pkg::sfp_status_t abs_stat;
	board_ctl_pkg::sfp_status_t los_stat;
	board_ctl_pkg::data_t       int_source;
	board_ctl_pkg::ctl_regs_t   ctl;
	board_ctl_pkg::rd_clr_t     rd_clr;
	logic                       tick;	// filter enable from the led timer

	// ------------------------------------------------------------
	// host registers
	// ------------------------------------------------------------
	lbus_regs u_regs (
		.clk(clk), .rst_n(rst_n), .lbus(lbus),
		.abs_stat(abs_stat), .los_stat(los_stat), .int_source(int_source),
		.rdata(lbus_rdata), .rdata_oe(rdata_oe), .rdy_n(rdy_n),
		.ctl(ctl), .rd_clr(rd_clr), .txdis(txdis),
		.tck(tck), .tdi(tdi), .tms(tms),
		.jtag_con(jtag_con), .jtag_sys(jtag_sys), .tdo(tdo)
	);

	// cage presence and fiber loss
	sfp_monitor abs_mon (
		.clk(clk), .rst_n(rst_n), .tick(tick),
		.pins(sfp_abs_pin), .clr(rd_clr.abs_evt), .stat(abs_stat)
	);

	sfp_monitor los_mon (
		.clk(clk), .rst_n(rst_n), .tick(tick),
		.pins(sfp_los_pin), .clr(rd_clr.los_evt), .stat(los_stat)
	);

	// interrupt and leds
	int_ctrl u_int (
		.clk(clk), .rst_n(rst_n), .int_mask(ctl.int_mask),
		.abs_sum(abs_stat.sum_n), .los_sum(los_stat.sum_n),
		.vmon_alarm_n(vmon_alarm_n), .temp_alarm_n(temp_alarm_n),
		.clr(rd_clr.int_src), .int_source(int_source), .int_n(int_n)
	);

	port_led u_led (
		.clk(clk), .rst_n(rst_n),
		.led_link(ctl.led_link), .led_act(ctl.led_act),
		.tick(tick), .blink(), .led(led)	// blink only used inside
	);

endmodule

`default_nettype wire

// ==== rtl/int_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module int_ctrl (
	input  wire                  clk,
	input  wire                  rst_n,
	input  board_ctl_pkg::data_t int_mask,	// 1 enables the source
	input  wire                  abs_sum,	// active low summaries
	input  wire                  los_sum,
	input  wire                  vmon_alarm_n,
	input  wire                  temp_alarm_n,
	input  wire                  clr,
	output board_ctl_pkg::data_t int_source,
	output logic                 int_n
);

	logic [1:0]           vmon_s;	// two-flop syncs, async pins
	logic [1:0]           temp_s;
	board_ctl_pkg::data_t src_n;	// raw sources before masking

	// ------------------------------------------------------------
	// alarm synchronisers
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vmon_s <= 2'b11;
			temp_s <= 2'b11;
		end
		else
		begin
			vmon_s <= {vmon_s[0], vmon_alarm_n};
			temp_s <= {temp_s[0], temp_alarm_n};
		end
	end

	// bits 7:4 reserved, tied high
	assign src_n = {4'hf, los_sum, abs_sum, temp_s[1], vmon_s[1]};

	// ------------------------------------------------------------
	// source register and host line
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			int_source <= '1;
			int_n      <= 1'b1;
		end
		else
		begin
			if (clr)
				int_source <= '1;	// live sources reassert next clock
			else
				int_source <= src_n | ~int_mask;	// masked bit reads 1
			int_n <= &int_source[3:0];
		end
	end

	// reserved bits never show a source
	a_rsvd_high: assert property (@(posedge clk) disable iff (!rst_n)
		int_source[7:4] == 4'hf);

endmodule

`default_nettype wire

// ==== rtl/lbus_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module lbus_regs (
	input  wire                       clk,
	input  wire                       rst_n,
	input  board_ctl_pkg::lbus_req_t  lbus,
	input  board_ctl_pkg::sfp_status_t abs_stat,
	input  board_ctl_pkg::sfp_status_t los_stat,
	input  board_ctl_pkg::data_t      int_source,
	output board_ctl_pkg::data_t      rdata,
	output logic                      rdata_oe,
	output logic                      rdy_n,
	output board_ctl_pkg::ctl_regs_t  ctl,
	output board_ctl_pkg::rd_clr_t    rd_clr,
	output board_ctl_pkg::port_vec_t  txdis,
	output logic                      tck,
	output logic                      tdi,
	output logic                      tms,
	output logic                      jtag_con,
	output logic                      jtag_sys,
	input  wire                       tdo
);

	logic                   wr_en;	// host write strobe
	logic                   rd_en;	// host read strobe
	board_ctl_pkg::data_t   test_q;
	board_ctl_pkg::data_t   rd_mux;
	board_ctl_pkg::rd_clr_t rc_pend;	// read-clear target of current read
	logic                   tdo_q;

	assign wr_en    = ~lbus.cs_n & ~lbus.wr_n;
	assign rd_en    = ~lbus.cs_n & ~lbus.rd_n;
	assign rdata_oe = rd_en;	// drive the data pads only while reading
	assign rdy_n    = ~(rd_en | wr_en);	// no wait states

	assign jtag_con = ctl.jtag_sel[0];
	assign jtag_sys = ~ctl.jtag_sel[0];

	// ------------------------------------------------------------
	// write side
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			test_q       <= board_ctl_pkg::RST_TEST;
			txdis        <= board_ctl_pkg::RST_TXDIS;
			ctl.int_mask <= board_ctl_pkg::RST_INT_MASK;
			ctl.led_link <= board_ctl_pkg::RST_LED_LINK;
			ctl.led_act  <= board_ctl_pkg::RST_LED_ACT;
			ctl.jtag_sel <= board_ctl_pkg::RST_JTAG_SEL;
			tdi          <= board_ctl_pkg::RST_TDI[0];
			tms          <= board_ctl_pkg::RST_TMS[0];
			tck          <= board_ctl_pkg::RST_TCK[0];
		end
		else if (wr_en)
		begin
			case (lbus.addr)
				board_ctl_pkg::A_TEST:     test_q       <= ~lbus.wdata;	// stored inverted
				board_ctl_pkg::A_INT_MASK: ctl.int_mask <= lbus.wdata;
				board_ctl_pkg::A_TDI:      tdi          <= lbus.wdata[0];
				board_ctl_pkg::A_TMS:      tms          <= lbus.wdata[0];
				board_ctl_pkg::A_TCK:      tck          <= lbus.wdata[0];
				board_ctl_pkg::A_TXDIS:    txdis        <= lbus.wdata;
				board_ctl_pkg::A_LED_LINK: ctl.led_link <= lbus.wdata;
				board_ctl_pkg::A_LED_ACT:  ctl.led_act  <= lbus.wdata;
				board_ctl_pkg::A_JTAG_SEL: ctl.jtag_sel <= lbus.wdata;
				default: ;	// read-only or unmapped
			endcase
		end
	end

	// tdo sampled every clock while the host owns the chain
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tdo_q <= 1'b0;
		else if (ctl.jtag_sel[0])
			tdo_q <= tdo;
	end

	// ------------------------------------------------------------
	// read side
	// ------------------------------------------------------------
	always_comb
	begin
		rd_mux = '0;	// unmapped reads as 00
		case (lbus.addr)
			board_ctl_pkg::A_TEST:          rd_mux = test_q;
			board_ctl_pkg::A_DATA_WIDTH:    rd_mux = board_ctl_pkg::ID_DATA_WIDTH;
			board_ctl_pkg::A_VERSION:       rd_mux = board_ctl_pkg::ID_VERSION;
			board_ctl_pkg::A_BUILD_MONTH:   rd_mux = board_ctl_pkg::ID_BUILD_MONTH;
			board_ctl_pkg::A_BUILD_DATE:    rd_mux = board_ctl_pkg::ID_BUILD_DATE;
			board_ctl_pkg::A_PCB_VERSION:   rd_mux = board_ctl_pkg::ID_PCB_VERSION;
			board_ctl_pkg::A_BOARD_VERSION: rd_mux = board_ctl_pkg::ID_BOARD_VERSION;
			board_ctl_pkg::A_BOARD_CONFIG:  rd_mux = board_ctl_pkg::ID_BOARD_CONFIG;
			board_ctl_pkg::A_INT_SOURCE:    rd_mux = int_source;
			board_ctl_pkg::A_INT_MASK:      rd_mux = ctl.int_mask;
			board_ctl_pkg::A_TDO:           rd_mux = {7'b0, tdo_q};
			board_ctl_pkg::A_TXDIS:         rd_mux = txdis;
			board_ctl_pkg::A_LED_LINK:      rd_mux = ctl.led_link;
			board_ctl_pkg::A_LED_ACT:       rd_mux = ctl.led_act;
			board_ctl_pkg::A_JTAG_SEL:      rd_mux = ctl.jtag_sel;
			board_ctl_pkg::A_SFP_PRESENT:   rd_mux = abs_stat.deb;
			board_ctl_pkg::A_SFP_LOS:       rd_mux = los_stat.deb;
			board_ctl_pkg::A_ABS_EVENT:     rd_mux = abs_stat.evt_n;
			board_ctl_pkg::A_LOS_EVENT:     rd_mux = los_stat.evt_n;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rdata <= '0;
		else if (rd_en)
			rdata <= rd_mux;	// held once the strobe ends
	end

	// remember a clear-on-read target, fire once the strobe drops
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rc_pend <= '0;
		else if (rd_en)
		begin
			rc_pend.int_src <= (lbus.addr == board_ctl_pkg::A_INT_SOURCE);
			rc_pend.abs_evt <= (lbus.addr == board_ctl_pkg::A_ABS_EVENT);
			rc_pend.los_evt <= (lbus.addr == board_ctl_pkg::A_LOS_EVENT);
		end
		else
			rc_pend <= '0;
	end

	assign rd_clr = rc_pend & {3{~rd_en}};	// first cycle after the read

	// clear pulses reach at most one block
	a_rd_clr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({rd_clr.int_src, rd_clr.abs_evt, rd_clr.los_evt}));

endmodule

`default_nettype wire

// ==== rtl/port_led.sv ====
`timescale 1ns/10ps
`default_nettype none

module port_led (
	input  wire                       clk,
	input  wire                       rst_n,
	input  board_ctl_pkg::port_vec_t  led_link,	// 1 forces the led off
	input  board_ctl_pkg::port_vec_t  led_act,	// 1 forces the led on
	output logic                      tick,	// one clock per divider wrap
	output logic                      blink,
	output board_ctl_pkg::port_vec_t  led	// active low drivers
);

	logic [board_ctl_pkg::BLINK_DIV_W-1:0] div;

	// ------------------------------------------------------------
	// blink timer
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			div  <= '0;
			tick <= 1'b0;
		end
		else
		begin
			div  <= div + 1'b1;
			tick <= &div;	// high the clock after the wrap
		end
	end

	assign blink = div[board_ctl_pkg::BLINK_DIV_W-1];

	// per port: link wins, then act, else flash
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			led <= '1;	// all dark
		else
		begin
			for (int i = 0; i < board_ctl_pkg::NUM_PORTS; i++)
			begin
				if (led_link[i])
					led[i] <= 1'b1;
				else if (led_act[i])
					led[i] <= 1'b0;
				else
					led[i] <= blink;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sfp_monitor.sv ====
`timescale 1ns/10ps
`default_nettype none

// one group of eight cage status pins (abs or los)
module sfp_monitor (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        tick,	// slow enable from the blink timer
	input  board_ctl_pkg::port_vec_t   pins,
	input  wire                        clr,	// read-clear of the event byte
	output board_ctl_pkg::sfp_status_t stat
);

	board_ctl_pkg::port_vec_t pad;	// last sample taken on a tick
	board_ctl_pkg::port_vec_t deb;	// accepted state
	board_ctl_pkg::port_vec_t deb_q;	// deb one clock back
	board_ctl_pkg::port_vec_t chg_n;	// low for one clock per changed bit
	board_ctl_pkg::port_vec_t evt_n;

	// ------------------------------------------------------------
	// debounce
	// ------------------------------------------------------------
	// a level must match on two ticks in a row before it is accepted
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pad <= '1;
			deb <= '1;
		end
		else if (tick)
		begin
			if (pins == pad)
				deb <= pad;	// stable, take it
			else
				pad <= pins;	// moved, sample again next tick
		end
	end

	// ------------------------------------------------------------
	// change detect
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			deb_q <= '1;
			chg_n <= '1;
		end
		else
		begin
			deb_q <= deb;
			chg_n <= ~(deb ^ deb_q);	// xnor, 0 where the bit moved
		end
	end

	// event latch, sticky low until the host reads it
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			evt_n <= '1;
		else if (clr)
			evt_n <= '1;
		else
			evt_n <= evt_n & chg_n;
	end

	assign stat = '{deb: deb, evt_n: evt_n, sum_n: &evt_n};

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	// read-clear leaves nothing pending
	a_clr_empty: assert property (@(posedge clk) disable iff (!rst_n)
		clr |=> (stat.evt_n == '1));

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+tb
rtl/board_ctl_pkg.sv
rtl/lbus_regs.sv
rtl/sfp_monitor.sv
rtl/int_ctrl.sv
rtl/port_led.sv
rtl/board_ctl_top.sv
tb/tb_board_ctl.sv

// ==== tb/tb_tests.svh ====
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH
`default_nettype none

// ------------------------------------------------------------
// bus cycles
// ------------------------------------------------------------
task automatic bus_write(input logic [9:0] addr, input logic [7:0] data);
	@(posedge clk);
	lbus.addr  <= addr;
	lbus.wdata <= data;
	lbus.cs_n  <= 1'b0;
	lbus.wr_n  <= 1'b0;
	@(posedge clk);	// write lands on this edge
	@(negedge clk);
	check_val("rdy_n", 1'b0, rdy_n);	// ready low on writes as well
	@(posedge clk);	// strobe seen on two edges
	lbus.cs_n  <= 1'b1;
	lbus.wr_n  <= 1'b1;
endtask

task automatic bus_read(input logic [9:0] addr, output logic [7:0] data);
	@(posedge clk);
	lbus.addr <= addr;
	lbus.cs_n <= 1'b0;
	lbus.rd_n <= 1'b0;
	repeat (2) @(posedge clk);
	@(negedge clk);	// last cycle of the strobe
	check_val("rdata_oe", 1'b1, rdata_oe);
	check_val("rdy_n", 1'b0, rdy_n);
	data = lbus_rdata;
	@(posedge clk);
	lbus.cs_n <= 1'b1;
	lbus.rd_n <= 1'b1;
endtask

task automatic check_read(input logic [9:0] addr, input logic [7:0] exp, input string name);
	logic [7:0] d;
	bus_read(addr, d);
	check_val(name, exp, d);
endtask

task automatic wait_int_n(input logic level, input int max_cycles);
	for (int i = 0; i < max_cycles; i++)
	begin
		@(negedge clk);
		if (int_n === level)
			return;
	end
	report_error($sformatf("int_n did not reach %b within %0d cycles", level, max_cycles));
endtask

// ------------------------------------------------------------
// tests
// ------------------------------------------------------------
task automatic test_reset_identity();
	begin_test("reset_identity");
	@(negedge clk);
	check_val("int_n", 1'b1, int_n);
	check_val("rdy_n", 1'b1, rdy_n);
	check_val("rdata_oe", 1'b0, rdata_oe);
	check_val("led", 8'hff, led);
	check_val("txdis", 8'h00, txdis);
	check_val("tck", 1'b0, tck);
	check_val("tdi", 1'b1, tdi);
	check_val("tms", 1'b1, tms);
	check_val("jtag_con", 1'b0, jtag_con);
	check_val("jtag_sys", 1'b1, jtag_sys);
	check_read(board_ctl_pkg::A_DATA_WIDTH, 8'h00, "data_width");
	check_read(board_ctl_pkg::A_VERSION, 8'h01, "version");
	check_read(board_ctl_pkg::A_BUILD_MONTH, 8'ha8, "build_month");
	check_read(board_ctl_pkg::A_BUILD_DATE, 8'h03, "build_date");
	check_read(board_ctl_pkg::A_PCB_VERSION, 8'h01, "pcb_version");
	check_read(board_ctl_pkg::A_BOARD_VERSION, 8'h01, "board_version");
	check_read(board_ctl_pkg::A_BOARD_CONFIG, 8'hff, "board_config");
	check_read(board_ctl_pkg::A_TEST, 8'h00, "test");
	check_read(10'h3ff, 8'h00, "unused 3ff");	// unmapped
	finish_test();
endtask

task automatic test_register_access();
	logic [7:0] d;
	begin_test("register_access");
	d = rand_byte();
	bus_write(board_ctl_pkg::A_TEST, d);
	check_read(board_ctl_pkg::A_TEST, ~d, "test");	// comes back inverted
	d = rand_byte();
	bus_write(board_ctl_pkg::A_TXDIS, d);
	@(negedge clk);
	check_val("txdis", d, txdis);
	check_read(board_ctl_pkg::A_TXDIS, d, "txdis reg");
	d = rand_byte();
	bus_write(board_ctl_pkg::A_INT_MASK, d);
	check_read(board_ctl_pkg::A_INT_MASK, d, "int_mask");
	d = rand_byte();
	bus_write(board_ctl_pkg::A_LED_LINK, d);
	check_read(board_ctl_pkg::A_LED_LINK, d, "led_link");
	d = rand_byte();
	bus_write(board_ctl_pkg::A_LED_ACT, d);
	check_read(board_ctl_pkg::A_LED_ACT, d, "led_act");
	d = rand_byte() | 8'h01;	// jtag_sel resets with bit 0 clear
	bus_write(board_ctl_pkg::A_JTAG_SEL, d);
	@(negedge clk);
	check_val("jtag_con", d[0], jtag_con);
	check_val("jtag_sys", !d[0], jtag_sys);
	check_read(board_ctl_pkg::A_JTAG_SEL, d, "jtag_sel");
	// jtag pins, write only
	d = rand_byte() | 8'h01;	// tck resets low
	bus_write(board_ctl_pkg::A_TCK, d);
	@(negedge clk);
	check_val("tck", d[0], tck);
	d = rand_byte() & 8'hfe;	// tdi resets high
	bus_write(board_ctl_pkg::A_TDI, d);
	@(negedge clk);
	check_val("tdi", d[0], tdi);
	d = rand_byte() & 8'hfe;	// tms resets high
	bus_write(board_ctl_pkg::A_TMS, d);
	@(negedge clk);
	check_val("tms", d[0], tms);
	// back to reset defaults for the later tests
	bus_write(board_ctl_pkg::A_INT_MASK, 8'hff);
	bus_write(board_ctl_pkg::A_LED_LINK, 8'hff);
	bus_write(board_ctl_pkg::A_LED_ACT, 8'hff);
	bus_write(board_ctl_pkg::A_JTAG_SEL, 8'h00);
	bus_write(board_ctl_pkg::A_TXDIS, 8'h00);
	finish_test();
endtask

task automatic test_tdo_capture();
	begin_test("tdo_capture");
	bus_write(board_ctl_pkg::A_JTAG_SEL, 8'h01);	// host owns the chain
	@(posedge clk);
	tdo <= 1'b1;
	check_read(board_ctl_pkg::A_TDO, 8'h01, "tdo high");
	@(posedge clk);
	tdo <= 1'b0;
	check_read(board_ctl_pkg::A_TDO, 8'h00, "tdo low");
	@(posedge clk);
	tdo <= 1'b1;
	check_read(board_ctl_pkg::A_TDO, 8'h01, "tdo high again");
	bus_write(board_ctl_pkg::A_JTAG_SEL, 8'h00);
	@(posedge clk);
	tdo <= 1'b0;	// no longer sampled
	check_read(board_ctl_pkg::A_TDO, 8'h01, "tdo held");
	finish_test();
endtask

task automatic test_sfp_events();
	logic [7:0] abs_chg;
	logic [7:0] los_chg;
	begin_test("sfp_events");
	abs_chg = rand_byte() | 8'h01;	// at least one bit moves
	los_chg = rand_byte() | 8'h80;
	@(posedge clk);
	sfp_abs_pin <= ~abs_chg;	// pins were ff
	sfp_los_pin <= ~los_chg;
	repeat (64) @(posedge clk);	// four ticks
	@(negedge clk);
	check_val("int_n", 1'b0, int_n);
	check_read(board_ctl_pkg::A_SFP_PRESENT, ~abs_chg, "sfp_present");
	check_read(board_ctl_pkg::A_SFP_LOS, ~los_chg, "sfp_los");
	check_read(board_ctl_pkg::A_INT_SOURCE, 8'hf3, "int_source");	// abs and los summaries
	check_read(board_ctl_pkg::A_ABS_EVENT, ~abs_chg, "abs_event");
	check_read(board_ctl_pkg::A_LOS_EVENT, ~los_chg, "los_event");
	check_read(board_ctl_pkg::A_ABS_EVENT, 8'hff, "abs_event cleared");
	check_read(board_ctl_pkg::A_LOS_EVENT, 8'hff, "los_event cleared");
	wait_int_n(1'b1, 8);
	finish_test();
endtask

task automatic test_int_mask();
	begin_test("int_mask");
	bus_write(board_ctl_pkg::A_INT_MASK, 8'hfd);	// temp alarm masked
	@(posedge clk);
	temp_alarm_n <= 1'b0;
	repeat (8) @(posedge clk);
	@(negedge clk);
	check_val("int_n", 1'b1, int_n);
	bus_write(board_ctl_pkg::A_INT_MASK, 8'hff);
	wait_int_n(1'b0, 8);
	check_read(board_ctl_pkg::A_INT_SOURCE, 8'hfd, "int_source");
	@(posedge clk);
	temp_alarm_n <= 1'b1;
	repeat (4) @(posedge clk);	// through the synchroniser
	check_read(board_ctl_pkg::A_INT_SOURCE, 8'hff, "int_source released");
	wait_int_n(1'b1, 8);
	finish_test();
endtask

task automatic test_leds();
	logic [3:0] first;
	logic       seen;
	begin_test("leds");
	bus_write(board_ctl_pkg::A_LED_LINK, 8'h00);
	bus_write(board_ctl_pkg::A_LED_ACT, 8'h0f);
	repeat (2) @(posedge clk);
	@(negedge clk);
	check_val("led[3:0]", 4'h0, led[3:0]);
	if (led[7:4] != 4'h0 && led[7:4] != 4'hf)
		report_error("leds 7:4 do not flash together");
	first = led[7:4];
	seen  = 1'b0;
	for (int i = 0; i < 16 && !seen; i++)
	begin
		@(negedge clk);
		if (led[7:4] != first)
			seen = 1'b1;
	end
	if (!seen)
		report_error("leds 7:4 did not toggle within 16 cycles");
	bus_write(board_ctl_pkg::A_LED_LINK, 8'hff);	// link forces all off
	@(negedge clk);
	check_val("led", 8'hff, led);
	bus_write(board_ctl_pkg::A_LED_ACT, 8'hff);
	finish_test();
endtask

`default_nettype wire
`endif

// ==== tb/tb_board_ctl.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_board_ctl;

	localparam int CLK_PERIOD   = 8;	// ns
	localparam int RESET_CYCLES = 5;
	// cycle budget per test, in run order
	localparam int TEST_CYCLES  = 60 + 140 + 60 + 160 + 110 + 60;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + 2 * TEST_CYCLES) * CLK_PERIOD;	// 2x margin

	logic                       clk;
	logic                       rst_n;
	board_ctl_pkg::lbus_req_t   lbus;	// host strobes, address, write data
	board_ctl_pkg::data_t       lbus_rdata;
	logic                       rdata_oe;
	logic                       rdy_n;
	logic                       int_n;
	board_ctl_pkg::port_vec_t   sfp_abs_pin;
	board_ctl_pkg::port_vec_t   sfp_los_pin;
	board_ctl_pkg::port_vec_t   txdis;
	board_ctl_pkg::port_vec_t   led;
	logic                       vmon_alarm_n;
	logic                       temp_alarm_n;
	logic                       tck;
	logic                       tdi;
	logic                       tms;
	logic                       jtag_con;
	logic                       jtag_sys;
	logic                       tdo;

	int          tests_run;
	int          tests_failed;
	int          errors;	// all failed checks
	int          test_errs;	// failed checks in the running test
	string       test_name;
	logic [31:0] rng_state = 32'd33;	// xorshift seed

	board_ctl_top dut (
		.clk(clk), .rst_n(rst_n), .lbus(lbus),
		.lbus_rdata(lbus_rdata), .rdata_oe(rdata_oe), .rdy_n(rdy_n), .int_n(int_n),
		.sfp_abs_pin(sfp_abs_pin), .sfp_los_pin(sfp_los_pin),
		.txdis(txdis), .led(led),
		.vmon_alarm_n(vmon_alarm_n), .temp_alarm_n(temp_alarm_n),
		.tck(tck), .tdi(tdi), .tms(tms),
		.jtag_con(jtag_con), .jtag_sys(jtag_sys), .tdo(tdo)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic logic [7:0] rand_byte();
		rng_state ^= rng_state << 13;	// xorshift32
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state[7:0];
	endfunction

	task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			$display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
			test_errs++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0t ns in test %s: %s", $time, test_name, msg);
		test_errs++;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
		tests_run++;
	endtask

	task automatic finish_test();
		errors += test_errs;
		if (test_errs == 0)
			$display("test %s: pass", test_name);
		else
		begin
			tests_failed++;
			$display("test %s: fail, %0d errors", test_name, test_errs);
		end
	endtask

	`include "tb_tests.svh"

	// hard stop if a test hangs
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		rst_n        = 1'b0;
		lbus.addr    = '0;
		lbus.wdata   = '0;
		lbus.cs_n    = 1'b1;	// bus idle
		lbus.wr_n    = 1'b1;
		lbus.rd_n    = 1'b1;
		sfp_abs_pin  = 8'hff;	// all cages empty
		sfp_los_pin  = 8'hff;
		vmon_alarm_n = 1'b1;
		temp_alarm_n = 1'b1;
		tdo          = 1'b0;
		tests_run    = 0;
		tests_failed = 0;
		errors       = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		test_reset_identity();
		test_register_access();
		test_tdo_capture();
		test_sfp_events();
		test_int_mask();
		test_leds();
		$display("tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
